// File: rtl/exu_pkg.sv
package exu_pkg;

    localparam int XLEN = 32;

    //////////////////////////////
    // opcodes
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    // funct3, alu ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3, branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct3, loads and stores
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // selects sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    //////////////////////////////
    // alu operation codes
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLL  = 4'd2;
    localparam logic [3:0] ALU_SLT  = 4'd3;
    localparam logic [3:0] ALU_SLTU = 4'd4;
    localparam logic [3:0] ALU_XOR  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_OR   = 4'd8;
    localparam logic [3:0] ALU_AND  = 4'd9;

    // one instruction word, register and store layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } inst_u;

endpackage

// File: rtl/exu_alu_if.sv
`timescale 1ns/1ps

interface exu_alu_if;
    import exu_pkg::*;

    logic [3:0]      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    logic            zero;
    logic            sign;

    modport ctrl (output op, a, b, input result, zero, sign);
    modport alu  (input op, a, b, output result, zero, sign);

endinterface

// File: rtl/exu_imm_gen.sv
`timescale 1ns/1ps

module exu_imm_gen (
    input  exu_pkg::inst_u              inst_i,
    output logic [exu_pkg::XLEN-1:0]    imm_o
);
    import exu_pkg::*;

    always_comb begin
        case (inst_i.r.opcode)
            // I format
            OP_IMM, OP_JALR, OP_LOAD: begin
                imm_o = {{20{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rs2};
            end
            OP_STORE: begin
                imm_o = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
            end
            // B format, imm[12|10:5] and imm[4:1|11]
            OP_BRANCH: begin
                imm_o = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_lo[0],
                         inst_i.s.imm_hi[5:0], inst_i.s.imm_lo[4:1], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm_o = {inst_i.r.funct7, inst_i.r.rs2, inst_i.r.rs1,
                         inst_i.r.funct3, 12'b0};
            end
            // J format, imm[20|10:1|11|19:12]
            OP_JAL: begin
                imm_o = {{12{inst_i.r.funct7[6]}}, inst_i.r.rs1, inst_i.r.funct3,
                         inst_i.r.rs2[0], inst_i.r.funct7[5:0], inst_i.r.rs2[4:1], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// File: rtl/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
    exu_alu_if.alu alu
);
    import exu_pkg::*;

    logic [4:0] shamt;

    assign shamt = alu.b[4:0];

    always_comb begin
        case (alu.op)
            ALU_ADD: begin
                alu.result = alu.a + alu.b;
            end
            ALU_SUB: begin
                alu.result = alu.a - alu.b;
            end
            ALU_SLL: begin
                alu.result = alu.a << shamt;
            end
            ALU_SLT: begin
                alu.result = {{(XLEN-1){1'b0}}, $signed(alu.a) < $signed(alu.b)};
            end
            ALU_SLTU: begin
                alu.result = {{(XLEN-1){1'b0}}, alu.a < alu.b};
            end
            ALU_XOR: begin
                alu.result = alu.a ^ alu.b;
            end
            ALU_SRL: begin
                alu.result = alu.a >> shamt;
            end
            ALU_SRA: begin
                alu.result = $signed(alu.a) >>> shamt;
            end
            ALU_OR: begin
                alu.result = alu.a | alu.b;
            end
            ALU_AND: begin
                alu.result = alu.a & alu.b;
            end
            default: begin
                alu.result = '0;
            end
        endcase
    end

    // flags for the branch compare
    assign alu.zero = (alu.result == '0);
    assign alu.sign = alu.result[XLEN-1];

endmodule

// File: rtl/exu_lsu_align.sv
`timescale 1ns/1ps

module exu_lsu_align (
    input  logic [2:0]                  funct3_i,
    input  logic [1:0]                  byte_off_i,
    input  logic [exu_pkg::XLEN-1:0]    mem_rd_data_i,
    input  logic [exu_pkg::XLEN-1:0]    rs2_data_i,
    output logic [exu_pkg::XLEN-1:0]    load_data_o,
    output logic [exu_pkg::XLEN-1:0]    store_data_o
);
    import exu_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // lane select
    assign ld_byte = mem_rd_data_i[{byte_off_i, 3'b000} +: 8];
    assign ld_half = (byte_off_i == 2'd0) ? mem_rd_data_i[15:0] : mem_rd_data_i[31:16];

    //////////////////////////////
    // loads
    always_comb begin
        case (funct3_i)
            F3_LB: begin
                load_data_o = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            end
            F3_LH: begin
                load_data_o = {{(XLEN-16){ld_half[15]}}, ld_half};
            end
            F3_LBU: begin
                load_data_o = {{(XLEN-8){1'b0}}, ld_byte};
            end
            F3_LHU: begin
                load_data_o = {{(XLEN-16){1'b0}}, ld_half};
            end
            F3_LW: begin
                load_data_o = mem_rd_data_i;
            end
            default: begin
                load_data_o = mem_rd_data_i;
            end
        endcase
    end

    //////////////////////////////
    // stores, merged into the old word
    always_comb begin
        store_data_o = mem_rd_data_i;
        case (funct3_i)
            F3_SB: begin
                store_data_o[{byte_off_i, 3'b000} +: 8] = rs2_data_i[7:0];
            end
            F3_SH: begin
                if (byte_off_i == 2'd0) begin
                    store_data_o[15:0] = rs2_data_i[15:0];
                end else begin
                    store_data_o[31:16] = rs2_data_i[15:0];
                end
            end
            F3_SW: begin
                store_data_o = rs2_data_i;
            end
            default: begin
                store_data_o = rs2_data_i;
            end
        endcase
    end

endmodule

// File: rtl/exu_ctrl.sv
`timescale 1ns/1ps

module exu_ctrl (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  exu_pkg::inst_u              inst_i,
    input  logic [exu_pkg::XLEN-1:0]    pc_i,
    input  logic [exu_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [exu_pkg::XLEN-1:0]    rs2_data_i,
    input  logic [exu_pkg::XLEN-1:0]    imm_i,
    input  logic [exu_pkg::XLEN-1:0]    load_data_i,
    input  logic [exu_pkg::XLEN-1:0]    store_data_i,

    exu_alu_if.ctrl                     alu,

    output logic                        out_valid_o,
    output logic                        reg_wr_en_o,
    output logic [4:0]                  reg_wr_addr_o,
    output logic [exu_pkg::XLEN-1:0]    reg_wr_data_o,
    output logic                        mem_wr_en_o,
    output logic [exu_pkg::XLEN-1:0]    mem_wr_data_o,
    output logic                        jump_flag_o,
    output logic [exu_pkg::XLEN-1:0]    jump_addr_o
);
    import exu_pkg::*;

    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] pc_plus_imm;
    logic [XLEN-1:0] jump_target;
    logic            alt;
    logic            br_valid;
    logic            br_on_zero;
    logic            reg_wr_en_d;
    logic            mem_wr_en_d;
    logic            jump_flag_d;
    logic [XLEN-1:0] reg_wr_data_d;
    logic [XLEN-1:0] mem_wr_data_d;
    logic [XLEN-1:0] jump_addr_d;

    assign pc_plus_4   = pc_i + XLEN'(4);
    assign pc_plus_imm = pc_i + imm_i;
    assign jump_target = {alu.result[XLEN-1:1], 1'b0};
    assign alt         = (inst_i.r.funct7 == F7_ALT);

    //////////////////////////////
    // alu operands and operation
    always_comb begin
        alu.op     = ALU_ADD;
        alu.a      = rs1_data_i;
        alu.b      = rs2_data_i;
        br_valid   = 1'b1;
        br_on_zero = 1'b0;
        case (inst_i.r.opcode)
            OP_IMM, OP_REG: begin
                if (inst_i.r.opcode == OP_IMM) begin
                    alu.b = imm_i;
                end
                case (inst_i.r.funct3)
                    F3_ADD:  alu.op = (inst_i.r.opcode == OP_REG && alt) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu.op = ALU_SLL;
                    F3_SLT:  alu.op = ALU_SLT;
                    F3_SLTU: alu.op = ALU_SLTU;
                    F3_XOR:  alu.op = ALU_XOR;
                    F3_SR:   alu.op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu.op = ALU_OR;
                    F3_AND:  alu.op = ALU_AND;
                endcase
            end
            OP_LUI: begin
                alu.a = '0;
                alu.b = imm_i;
            end
            OP_AUIPC, OP_JAL: begin
                alu.a = pc_i;
                alu.b = imm_i;
            end
            OP_JALR: begin
                alu.b = imm_i;
            end
            // slt and sltu give 1 when less, sub gives 0 when equal
            OP_BRANCH: begin
                case (inst_i.r.funct3)
                    F3_BEQ: begin
                        alu.op     = ALU_SUB;
                        br_on_zero = 1'b1;
                    end
                    F3_BNE:  alu.op = ALU_SUB;
                    F3_BLT:  alu.op = ALU_SLT;
                    F3_BGE: begin
                        alu.op     = ALU_SLT;
                        br_on_zero = 1'b1;
                    end
                    F3_BLTU: alu.op = ALU_SLTU;
                    F3_BGEU: begin
                        alu.op     = ALU_SLTU;
                        br_on_zero = 1'b1;
                    end
                    default: br_valid = 1'b0;
                endcase
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////
    // write-back, memory and jump
    always_comb begin
        reg_wr_en_d   = 1'b0;
        reg_wr_data_d = '0;
        mem_wr_en_d   = 1'b0;
        mem_wr_data_d = '0;
        jump_flag_d   = 1'b0;
        jump_addr_d   = '0;
        case (inst_i.r.opcode)
            OP_IMM, OP_REG, OP_LUI, OP_AUIPC: begin
                reg_wr_en_d   = 1'b1;
                reg_wr_data_d = alu.result;
            end
            OP_JAL, OP_JALR: begin
                reg_wr_en_d   = 1'b1;
                reg_wr_data_d = pc_plus_4;
                jump_flag_d   = 1'b1;
                jump_addr_d   = jump_target;
            end
            OP_BRANCH: begin
                jump_flag_d = br_valid && (alu.zero == br_on_zero);
                jump_addr_d = jump_flag_d ? pc_plus_imm : '0;
            end
            OP_LOAD: begin
                reg_wr_en_d   = 1'b1;
                reg_wr_data_d = load_data_i;
            end
            OP_STORE: begin
                mem_wr_en_d   = 1'b1;
                mem_wr_data_d = store_data_i;
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////
    // output stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
            reg_wr_en_o <= 1'b0;
            mem_wr_en_o <= 1'b0;
            jump_flag_o <= 1'b0;
        end else begin
            out_valid_o <= valid_i;
            reg_wr_en_o <= valid_i & reg_wr_en_d;
            mem_wr_en_o <= valid_i & mem_wr_en_d;
            jump_flag_o <= valid_i & jump_flag_d;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            reg_wr_addr_o <= inst_i.r.rd;
            reg_wr_data_o <= reg_wr_data_d;
            mem_wr_data_o <= mem_wr_data_d;
            jump_addr_o   <= jump_addr_d;
        end
    end

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  logic [31:0]                 inst_i,
    input  logic [exu_pkg::XLEN-1:0]    pc_i,
    input  logic [exu_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [exu_pkg::XLEN-1:0]    rs2_data_i,
    input  logic [1:0]                  mem_byte_off_i,
    input  logic [exu_pkg::XLEN-1:0]    mem_rd_data_i,
    output logic                        out_valid_o,
    output logic                        reg_wr_en_o,
    output logic [4:0]                  reg_wr_addr_o,
    output logic [exu_pkg::XLEN-1:0]    reg_wr_data_o,
    output logic                        mem_wr_en_o,
    output logic [exu_pkg::XLEN-1:0]    mem_wr_data_o,
    output logic                        jump_flag_o,
    output logic [exu_pkg::XLEN-1:0]    jump_addr_o
);
    import exu_pkg::*;

    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] store_data;

    exu_alu_if u_alu_if ();

    exu_imm_gen u_imm_gen (
        .inst_i (inst_i),
        .imm_o  (imm)
    );

    exu_alu u_alu (
        .alu (u_alu_if)
    );

    // funct3 sits in bits 14:12
    exu_lsu_align u_lsu_align (
        .funct3_i      (inst_i[14:12]),
        .byte_off_i    (mem_byte_off_i),
        .mem_rd_data_i (mem_rd_data_i),
        .rs2_data_i    (rs2_data_i),
        .load_data_o   (load_data),
        .store_data_o  (store_data)
    );

    exu_ctrl u_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .imm_i         (imm),
        .load_data_i   (load_data),
        .store_data_i  (store_data),
        .alu           (u_alu_if),
        .out_valid_o   (out_valid_o),
        .reg_wr_en_o   (reg_wr_en_o),
        .reg_wr_addr_o (reg_wr_addr_o),
        .reg_wr_data_o (reg_wr_data_o),
        .mem_wr_en_o   (mem_wr_en_o),
        .mem_wr_data_o (mem_wr_data_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o)
    );

endmodule

// File: include/exu_ref.svh
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

// expected outputs of one instruction, payloads are zero when not enabled
function automatic void exu_ref(
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] rs1,
    input  logic [31:0] rs2,
    input  logic [1:0]  byte_off,
    input  logic [31:0] mem_rd,
    output logic        reg_wr_en,
    output logic [4:0]  reg_wr_addr,
    output logic [31:0] reg_wr_data,
    output logic        mem_wr_en,
    output logic [31:0] mem_wr_data,
    output logic        jump_flag,
    output logic [31:0] jump_addr
);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] opb;
    logic [31:0] res;
    logic [4:0]  sh;
    logic [7:0]  byte_v;
    logic [15:0] half_v;

    op     = inst[6:0];
    f3     = inst[14:12];
    alt    = (inst[31:25] == 7'b0100000);
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u  = {inst[31:12], 12'b0};
    imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    byte_v = mem_rd[8*byte_off +: 8];
    half_v = (byte_off == 2'd0) ? mem_rd[15:0] : mem_rd[31:16];

    reg_wr_en   = 1'b0;
    reg_wr_addr = inst[11:7];
    reg_wr_data = '0;
    mem_wr_en   = 1'b0;
    mem_wr_data = '0;
    jump_flag   = 1'b0;
    jump_addr   = '0;

    case (op)
        7'b0010011, 7'b0110011: begin
            opb = (op == 7'b0010011) ? imm_i : rs2;
            sh  = opb[4:0];
            case (f3)
                3'b000: res = (op == 7'b0110011 && alt) ? rs1 - opb : rs1 + opb;
                3'b001: res = rs1 << sh;
                3'b010: res = {31'b0, $signed(rs1) < $signed(opb)};
                3'b011: res = {31'b0, rs1 < opb};
                3'b100: res = rs1 ^ opb;
                3'b101: begin
                    if (alt) begin
                        res = $signed(rs1) >>> sh;
                    end else begin
                        res = rs1 >> sh;
                    end
                end
                3'b110: res = rs1 | opb;
                default: res = rs1 & opb;
            endcase
            reg_wr_en   = 1'b1;
            reg_wr_data = res;
        end
        7'b0110111, 7'b0010111: begin
            reg_wr_en   = 1'b1;
            reg_wr_data = (op == 7'b0110111) ? imm_u : pc + imm_u;
        end
        7'b1101111, 7'b1100111: begin
            reg_wr_en   = 1'b1;
            reg_wr_data = pc + 32'd4;
            jump_flag   = 1'b1;
            res         = (op == 7'b1101111) ? pc + imm_j : rs1 + imm_i;
            jump_addr   = {res[31:1], 1'b0};
        end
        7'b1100011: begin
            case (f3)
                3'b000: jump_flag = (rs1 == rs2);
                3'b001: jump_flag = (rs1 != rs2);
                3'b100: jump_flag = ($signed(rs1) < $signed(rs2));
                3'b101: jump_flag = ($signed(rs1) >= $signed(rs2));
                3'b110: jump_flag = (rs1 < rs2);
                3'b111: jump_flag = (rs1 >= rs2);
                default: jump_flag = 1'b0;
            endcase
            jump_addr = jump_flag ? pc + imm_b : '0;
        end
        7'b0000011: begin
            reg_wr_en = 1'b1;
            case (f3)
                3'b000: reg_wr_data = {{24{byte_v[7]}}, byte_v};
                3'b001: reg_wr_data = {{16{half_v[15]}}, half_v};
                3'b100: reg_wr_data = {24'b0, byte_v};
                3'b101: reg_wr_data = {16'b0, half_v};
                default: reg_wr_data = mem_rd;
            endcase
        end
        7'b0100011: begin
            mem_wr_en   = 1'b1;
            mem_wr_data = mem_rd;
            case (f3)
                3'b000: mem_wr_data[8*byte_off +: 8] = rs2[7:0];
                3'b001: begin
                    if (byte_off == 2'd0) begin
                        mem_wr_data[15:0] = rs2[15:0];
                    end else begin
                        mem_wr_data[31:16] = rs2[15:0];
                    end
                end
                default: mem_wr_data = rs2;
            endcase
        end
        default: begin
        end
    endcase
endfunction

`endif

// File: dv/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    typedef struct packed {
        logic        reg_wr_en;
        logic [4:0]  reg_wr_addr;
        logic [31:0] reg_wr_data;
        logic        mem_wr_en;
        logic [31:0] mem_wr_data;
        logic        jump_flag;
        logic [31:0] jump_addr;
    } exp_t;

    logic        clk;
    logic        reset_i;
    logic        valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic [1:0]  mem_byte_off_i;
    logic [31:0] mem_rd_data_i;
    logic        out_valid_o;
    logic        reg_wr_en_o;
    logic [4:0]  reg_wr_addr_o;
    logic [31:0] reg_wr_data_o;
    logic        mem_wr_en_o;
    logic [31:0] mem_wr_data_o;
    logic        jump_flag_o;
    logic [31:0] jump_addr_o;

    integer seed;
    logic   checking;
    exp_t   exp_q[$];

    `include "exu_ref.svh"

    exu_top u_exu_top (
        .clk            (clk),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .mem_byte_off_i (mem_byte_off_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .out_valid_o    (out_valid_o),
        .reg_wr_en_o    (reg_wr_en_o),
        .reg_wr_addr_o  (reg_wr_addr_o),
        .reg_wr_data_o  (reg_wr_data_o),
        .mem_wr_en_o    (mem_wr_en_o),
        .mem_wr_data_o  (mem_wr_data_o),
        .jump_flag_o    (jump_flag_o),
        .jump_addr_o    (jump_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // random instruction of one class with legal funct fields
    function automatic logic [31:0] gen_inst(input int cls);
        logic [31:0] inst;
        int          k;
        inst = $random(seed);
        k    = {$random(seed)} % 6;
        case (cls)
            0: begin
                inst[6:0] = OP_IMM;
                if (inst[14:12] == 3'b001) begin
                    inst[31:25] = 7'b0;
                end else if (inst[14:12] == 3'b101) begin
                    inst[31:25] = inst[30] ? F7_ALT : 7'b0;
                end
            end
            1: begin
                inst[6:0] = OP_REG;
                if ((inst[14:12] == 3'b000 || inst[14:12] == 3'b101) && inst[30]) begin
                    inst[31:25] = F7_ALT;
                end else begin
                    inst[31:25] = 7'b0;
                end
            end
            2: inst[6:0] = OP_LUI;
            3: inst[6:0] = OP_AUIPC;
            4: inst[6:0] = OP_JAL;
            5: begin
                inst[6:0]   = OP_JALR;
                inst[14:12] = 3'b000;
            end
            // funct3 0, 1, 4..7
            6: begin
                inst[6:0]   = OP_BRANCH;
                inst[14:12] = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
            end
            7: begin
                k           = k % 5;
                inst[6:0]   = OP_LOAD;
                inst[14:12] = (k < 3) ? k[2:0] : k[2:0] + 3'd1;
            end
            default: begin
                k           = k % 3;
                inst[6:0]   = OP_STORE;
                inst[14:12] = k[2:0];
            end
        endcase
        return inst;
    endfunction

    // drives one cycle on the falling edge and queues the expected result once accepted
    task automatic send_inst(input logic valid);
        int          cls;
        logic [31:0] r;
        exp_t        e;
        logic        w_en;
        logic [4:0]  w_addr;
        logic [31:0] w_data;
        logic        m_en;
        logic [31:0] m_data;
        logic        j_flag;
        logic [31:0] j_addr;
        @(negedge clk);
        cls            = {$random(seed)} % 9;
        r              = $random(seed);
        valid_i        = valid;
        inst_i         = gen_inst(cls);
        pc_i           = {r[31:2], 2'b00};
        rs1_data_i     = $random(seed);
        rs2_data_i     = $random(seed);
        mem_rd_data_i  = $random(seed);
        mem_byte_off_i = r[1:0];
        // equal operands now and then so beq and bge get taken
        if (cls == 6 && r[3:2] == 2'b00) begin
            rs2_data_i = rs1_data_i;
        end
        exu_ref(inst_i, pc_i, rs1_data_i, rs2_data_i, mem_byte_off_i, mem_rd_data_i,
                w_en, w_addr, w_data, m_en, m_data, j_flag, j_addr);
        e = '{w_en, w_addr, w_data, m_en, m_data, j_flag, j_addr};
        @(posedge clk);
        if (valid) begin
            exp_q.push_back(e);
        end
    endtask

    ////////////////////////////////
    // compare on the falling edge while outputs are stable
    initial begin
        exp_t e;
        forever begin
            @(negedge clk);
            if (checking) begin
                check_val("out_valid_o", {31'b0, out_valid_o}, {31'b0, exp_q.size() != 0});
                if (out_valid_o) begin
                    e = exp_q.pop_front();
                    check_val("reg_wr_en_o", {31'b0, reg_wr_en_o}, {31'b0, e.reg_wr_en});
                    check_val("reg_wr_addr_o", {27'b0, reg_wr_addr_o}, {27'b0, e.reg_wr_addr});
                    check_val("reg_wr_data_o", reg_wr_data_o, e.reg_wr_data);
                    check_val("mem_wr_en_o", {31'b0, mem_wr_en_o}, {31'b0, e.mem_wr_en});
                    check_val("mem_wr_data_o", mem_wr_data_o, e.mem_wr_data);
                    check_val("jump_flag_o", {31'b0, jump_flag_o}, {31'b0, e.jump_flag});
                    check_val("jump_addr_o", jump_addr_o, e.jump_addr);
                end else begin
                    check_val("idle reg_wr_en_o", {31'b0, reg_wr_en_o}, 32'd0);
                    check_val("idle mem_wr_en_o", {31'b0, mem_wr_en_o}, 32'd0);
                    check_val("idle jump_flag_o", {31'b0, jump_flag_o}, 32'd0);
                end
            end
        end
    end

    ////////////////////////////////
    // main sequence
    initial begin
        int          i;
        int          n;
        logic [31:0] r;
        seed           = 32'h1b5d;
        checking       = 1'b0;
        reset_i        = 1'b1;
        valid_i        = 1'b0;
        inst_i         = '0;
        pc_i           = '0;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        mem_byte_off_i = '0;
        mem_rd_data_i  = '0;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        @(posedge clk);
        checking = 1'b1;

        for (i = 0; i < 8; i++) begin
            send_inst(1'b0);
        end
        // back to back
        for (i = 0; i < 500; i++) begin
            send_inst(1'b1);
        end
        // idle cycles mixed in
        for (i = 0; i < 500; i++) begin
            r = $random(seed);
            send_inst(r[1:0] != 2'b00);
        end

        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            send_inst(1'b0);
            n = n + 1;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results still missing after 20 cycles", exp_q.size());
            $display("Test failed");
            $fatal(1, "timeout");
        end
        repeat (4) send_inst(1'b0);

        $display("Test passed");
        $finish;
    end

endmodule

// File: exu.f
+incdir+include
rtl/exu_pkg.sv
rtl/exu_alu_if.sv
rtl/exu_imm_gen.sv
rtl/exu_alu.sv
rtl/exu_lsu_align.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
dv/exu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f exu.f --top-module exu_tb -o exu_sim \
    && ./obj_dir/exu_sim | grep -x "Test passed" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
